// File: logic/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import dlx_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire logic   stall,
    input  wire if_id_t if_id,
    input  wire word_t  rd_a,
    input  wire word_t  rd_b,
    output reg_idx_t    rs_a,
    output reg_idx_t    rs_b,
    output id_ex_t      id_ex
);

    word_t   instr;
    opcode_t opcode;
    funct_t  funct;
    id_ex_t  id_next;

    assign instr  = if_id.instr;
    assign opcode = opcode_t'(instr[31:26]);
    assign funct  = funct_t'(instr[5:0]);

    // source fields sit in the same place for both formats
    assign rs_a = instr[25:21];
    assign rs_b = instr[20:16];

    ////////////////////////////////////////////////////////////////////////////
    // field split and control
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        id_next        = '0;
        id_next.op_a   = rd_a;
        id_next.op_b   = rd_b;
        // imm16 sign extended
        id_next.imm    = {{16{instr[15]}}, instr[15:0]};
        id_next.rs1    = instr[25:21];
        id_next.rs2    = instr[20:16];
        // I-type target, R-type overrides below
        id_next.rd     = instr[20:16];
        id_next.alu_op = alu_add;
        case (opcode)
            op_rtype: begin
                id_next.rd        = instr[15:11];
                id_next.reg_write = 1'b1;
                case (funct)
                    fn_add:  id_next.alu_op = alu_add;
                    fn_sub:  id_next.alu_op = alu_sub;
                    fn_and:  id_next.alu_op = alu_and;
                    fn_or:   id_next.alu_op = alu_or;
                    fn_slt:  id_next.alu_op = alu_slt;
                    // unknown funct, no-op
                    default: id_next.reg_write = 1'b0;
                endcase
            end
            op_addi: begin
                id_next.use_imm   = 1'b1;
                id_next.reg_write = 1'b1;
            end
            // address is base plus offset in the ALU
            op_lw: begin
                id_next.use_imm   = 1'b1;
                id_next.reg_write = 1'b1;
                id_next.mem_read  = 1'b1;
            end
            // rs2 carries the store data
            op_sw: begin
                id_next.use_imm   = 1'b1;
                id_next.mem_write = 1'b1;
            end
            // unknown opcode runs as a no-op
            default: id_next.reg_write = 1'b0;
        endcase
        id_next.valid = if_id.valid;
        if (!if_id.valid) begin
            id_next.reg_write = 1'b0;
            id_next.mem_read  = 1'b0;
            id_next.mem_write = 1'b0;
        end
    end

    // ID/EX register
    // a stall turns this slot into a bubble
    always_ff @(posedge clk) begin
        id_ex <= id_next;
        if (reset || stall) begin
            id_ex.valid     <= 1'b0;
            id_ex.reg_write <= 1'b0;
            id_ex.mem_read  <= 1'b0;
            id_ex.mem_write <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: logic/dlx_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module dlx_pipeline
    import dlx_pkg::*;
#(
    parameter word_t reset_pc = '0
) (
    input  wire logic  clk,
    input  wire logic  reset,
    output word_t      imem_addr,
    input  wire word_t imem_data,
    output dmem_req_t  dmem_req,
    input  wire word_t dmem_rdata,
    output wb_trace_t  wb_trace
);

    ////////////////////////////////////////////////////////////////////////////
    // stage to stage
    ////////////////////////////////////////////////////////////////////////////

    if_id_t   if_id;
    id_ex_t   id_ex;
    ex_mem_t  ex_mem;
    mem_wb_t  mem_wb;
    // hazard unit outputs
    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;
    logic     stall;
    // register file ports
    reg_idx_t rs_a;
    reg_idx_t rs_b;
    word_t    rd_a;
    word_t    rd_b;
    word_t    wb_value;

    fetch_stage #(.reset_pc(reset_pc)) u_fetch (
        .clk(clk), .reset(reset), .stall(stall),
        .imem_addr(imem_addr), .imem_data(imem_data), .if_id(if_id)
    );

    decode_stage u_decode (
        .clk(clk), .reset(reset), .stall(stall), .if_id(if_id),
        .rd_a(rd_a), .rd_b(rd_b), .rs_a(rs_a), .rs_b(rs_b), .id_ex(id_ex)
    );

    // written from wb, read from decode
    register_file u_regs (
        .clk(clk), .reset(reset), .rs_a(rs_a), .rs_b(rs_b),
        .rd_a(rd_a), .rd_b(rd_b), .wr(mem_wb), .wr_value(wb_value)
    );

    hazard_control u_hazard (
        .clk(clk), .reset(reset), .if_id(if_id), .id_ex(id_ex),
        .ex_mem(ex_mem), .mem_wb(mem_wb), .fwd_a(fwd_a), .fwd_b(fwd_b), .stall(stall)
    );

    // mem stage forwards its ALU result, wb stage its final value
    execute_stage u_execute (
        .clk(clk), .reset(reset), .id_ex(id_ex), .fwd_a(fwd_a), .fwd_b(fwd_b),
        .mem_fwd(ex_mem.alu_result), .wb_fwd(wb_value), .ex_mem(ex_mem)
    );

    memory_writeback u_mem_wb (
        .clk(clk), .reset(reset), .ex_mem(ex_mem), .dmem_req(dmem_req),
        .dmem_rdata(dmem_rdata), .mem_wb(mem_wb), .wb_value(wb_value), .wb_trace(wb_trace)
    );

endmodule

`default_nettype wire

// File: logic/dlx_pkg.sv
`default_nettype none

package dlx_pkg;

    // data and address words share one width
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    ////////////////////////////////////////////////////////////////////////////
    // instruction encodings
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_addi  = 6'h08,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_t;

    // funct field, R-type only
    typedef enum logic [5:0] {
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_slt = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt
    } alu_op_t;

    // where an EX operand comes from
    typedef enum logic [1:0] {
        fwd_reg,
        fwd_mem,
        fwd_wb
    } fwd_sel_t;

    // all zero: R-type with a funct nobody decodes, so nothing is written
    localparam word_t nop_instr = 32'h0000_0000;

    ////////////////////////////////////////////////////////////////////////////
    // stage registers and external buses
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic  valid;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        word_t    op_a;
        word_t    op_b;
        word_t    imm;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        alu_op_t  alu_op;
        logic     use_imm;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        word_t    alu_result;
        word_t    store_data;
        reg_idx_t rd;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        word_t    alu_result;
        word_t    load_data;
        reg_idx_t rd;
        logic     reg_write;
        logic     mem_read;
    } mem_wb_t;

    // data port, byte address with the two low bits ignored by the memory
    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  we;
        logic  re;
    } dmem_req_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    value;
    } wb_trace_t;

endpackage

`default_nettype wire

// File: logic/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage
    import dlx_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire id_ex_t   id_ex,
    input  wire fwd_sel_t fwd_a,
    input  wire fwd_sel_t fwd_b,
    input  wire word_t    mem_fwd,
    input  wire word_t    wb_fwd,
    output ex_mem_t       ex_mem
);

    word_t src_a;
    word_t src_b;
    word_t alu_b;
    word_t result;

    ////////////////////////////////////////////////////////////////////////////
    // operand select
    ////////////////////////////////////////////////////////////////////////////

    function automatic word_t forward(input fwd_sel_t sel, input word_t reg_val);
        case (sel)
            fwd_mem: return mem_fwd;
            fwd_wb:  return wb_fwd;
            default: return reg_val;
        endcase
    endfunction

    always_comb src_a = forward(fwd_a, id_ex.op_a);
    always_comb src_b = forward(fwd_b, id_ex.op_b);

    // immediate for addi, lw and sw
    // src_b still goes on as store data
    assign alu_b = id_ex.use_imm ? id_ex.imm : src_b;

    // ALU
    always_comb begin
        case (id_ex.alu_op)
            alu_add: result = src_a + alu_b;
            alu_sub: result = src_a - alu_b;
            alu_and: result = src_a & alu_b;
            alu_or:  result = src_a | alu_b;
            // signed compare
            alu_slt: result = {31'd0, $signed(src_a) < $signed(alu_b)};
            default: result = src_a + alu_b;
        endcase
    end

    // EX/MEM register
    always_ff @(posedge clk) begin
        ex_mem.valid      <= id_ex.valid;
        ex_mem.alu_result <= result;
        ex_mem.store_data <= src_b;
        ex_mem.rd         <= id_ex.rd;
        ex_mem.reg_write  <= id_ex.reg_write;
        ex_mem.mem_read   <= id_ex.mem_read;
        ex_mem.mem_write  <= id_ex.mem_write;
        if (reset) begin
            ex_mem.valid     <= 1'b0;
            ex_mem.reg_write <= 1'b0;
            ex_mem.mem_read  <= 1'b0;
            ex_mem.mem_write <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: logic/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage
    import dlx_pkg::*;
#(
    parameter word_t reset_pc = '0
) (
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire logic  stall,
    output word_t      imem_addr,
    input  wire word_t imem_data,
    output if_id_t     if_id
);

    word_t pc;

    // imem answers within the cycle, so pc goes straight out
    assign imem_addr = pc;

    // pc freezes while decode waits on a load
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (!stall) begin
            pc <= pc + 32'd4;
        end
    end

    // IF/ID register
    // held as is under stall so the waiting instruction decodes again
    always_ff @(posedge clk) begin
        if (!stall) begin
            if_id.valid <= 1'b1;
            if_id.instr <= imem_data;
        end
        if (reset) begin
            if_id.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: logic/hazard_control.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_control
    import dlx_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire if_id_t  if_id,
    input  wire id_ex_t  id_ex,
    input  wire ex_mem_t ex_mem,
    input  wire mem_wb_t mem_wb,
    output fwd_sel_t     fwd_a,
    output fwd_sel_t     fwd_b,
    output logic         stall
);

    opcode_t  id_opcode;
    reg_idx_t id_rs1;
    reg_idx_t id_rs2;
    logic     uses_rs1;
    logic     uses_rs2;

    ////////////////////////////////////////////////////////////////////////////
    // forwarding into EX
    ////////////////////////////////////////////////////////////////////////////

    // mem stage wins over wb, a load in mem has no data yet
    function automatic fwd_sel_t pick_source(input reg_idx_t src);
        fwd_sel_t sel;
        sel = fwd_reg;
        if (src != 5'd0) begin
            if (ex_mem.valid && ex_mem.reg_write && !ex_mem.mem_read && (ex_mem.rd == src)) begin
                sel = fwd_mem;
            end else if (mem_wb.valid && mem_wb.reg_write && (mem_wb.rd == src)) begin
                sel = fwd_wb;
            end
        end
        return sel;
    endfunction

    always_comb fwd_a = pick_source(id_ex.rs1);
    always_comb fwd_b = pick_source(id_ex.rs2);

    // load-use check against the instruction in ID
    assign id_opcode = opcode_t'(if_id.instr[31:26]);
    assign id_rs1    = if_id.instr[25:21];
    assign id_rs2    = if_id.instr[20:16];

    // addi and lw carry rd where rs2 would be
    assign uses_rs1 = id_opcode inside {op_rtype, op_addi, op_lw, op_sw};
    assign uses_rs2 = id_opcode inside {op_rtype, op_sw};

    assign stall = if_id.valid && id_ex.valid && id_ex.mem_read && (id_ex.rd != 5'd0)
                   && ((uses_rs1 && (id_ex.rd == id_rs1)) || (uses_rs2 && (id_ex.rd == id_rs2)));

    // the bubble behind a stall never re-triggers one
    a_single_bubble: assert property (
        @(posedge clk) disable iff (reset)
        stall |=> !stall
    ) else $error("load-use stall held for two cycles");

endmodule

`default_nettype wire

// File: logic/memory_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module memory_writeback
    import dlx_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire ex_mem_t ex_mem,
    output dmem_req_t    dmem_req,
    input  wire word_t   dmem_rdata,
    output mem_wb_t      mem_wb,
    output word_t        wb_value,
    output wb_trace_t    wb_trace
);

    // data port, read comes back in the same cycle
    always_comb begin
        dmem_req.addr  = ex_mem.alu_result;
        dmem_req.wdata = ex_mem.store_data;
        dmem_req.we    = ex_mem.valid && ex_mem.mem_write;
        dmem_req.re    = ex_mem.valid && ex_mem.mem_read;
    end

    // MEM/WB register
    always_ff @(posedge clk) begin
        mem_wb.valid      <= ex_mem.valid;
        mem_wb.alu_result <= ex_mem.alu_result;
        mem_wb.load_data  <= dmem_rdata;
        mem_wb.rd         <= ex_mem.rd;
        mem_wb.reg_write  <= ex_mem.reg_write;
        mem_wb.mem_read   <= ex_mem.mem_read;
        if (reset) begin
            mem_wb.valid     <= 1'b0;
            mem_wb.reg_write <= 1'b0;
            mem_wb.mem_read  <= 1'b0;
        end
    end

    // loads retire memory data, all else the ALU result
    assign wb_value = mem_wb.mem_read ? mem_wb.load_data : mem_wb.alu_result;

    // retire trace, r0 targets stay silent
    always_comb begin
        wb_trace.valid = mem_wb.valid && mem_wb.reg_write && (mem_wb.rd != 5'd0);
        wb_trace.rd    = mem_wb.rd;
        wb_trace.value = wb_value;
    end

    a_one_access: assert property (
        @(posedge clk) disable iff (reset)
        !(dmem_req.we && dmem_req.re)
    ) else $error("data port read and write in the same cycle");

endmodule

`default_nettype wire

// File: logic/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file
    import dlx_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire reg_idx_t rs_a,
    input  wire reg_idx_t rs_b,
    output word_t         rd_a,
    output word_t         rd_b,
    input  wire mem_wb_t  wr,
    input  wire word_t    wr_value
);

    // r1..r31, r0 has no storage
    word_t [31:1] regs;
    logic         wr_en;

    assign wr_en = wr.valid && wr.reg_write && (wr.rd != 5'd0);

    always_ff @(posedge clk) begin
        if (reset) begin
            regs <= '0;
        end else if (wr_en) begin
            regs[wr.rd] <= wr_value;
        end
    end

    // write-through so decode sees the value retiring this cycle
    function automatic word_t read_port(input reg_idx_t idx);
        if (idx == 5'd0) begin
            return '0;
        end else if (wr_en && (wr.rd == idx)) begin
            return wr_value;
        end
        return regs[idx];
    endfunction

    always_comb rd_a = read_port(rs_a);
    always_comb rd_b = read_port(rs_b);

    // r0 writes must be dropped
    a_r0_write_dropped: assert property (
        @(posedge clk) disable iff (reset)
        (wr.valid && wr.reg_write && (wr.rd == 5'd0)) |=> $stable(regs)
    ) else $error("register file changed on a write to r0");

endmodule

`default_nettype wire

// File: sources.f
logic/dlx_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/register_file.sv
logic/hazard_control.sv
logic/execute_stage.sv
logic/memory_writeback.sv
logic/dlx_pipeline.sv
tests/dlx_checker.sv
tests/tb_dlx_pipeline.sv

// File: tests/dlx_checker.sv
`timescale 1ns/1ps
`default_nettype none

module dlx_checker
    import dlx_pkg::*;
#(
    parameter word_t reset_pc = '0
) (
    input wire logic      clk,
    input wire logic      reset,
    input wire word_t     imem_addr,
    input wire wb_trace_t wb_trace,
    input wire dmem_req_t dmem_req
);

    // expected retires and stores in program order
    reg_idx_t exp_rd [$];
    word_t    exp_value [$];
    word_t    exp_addr [$];
    word_t    exp_data [$];

    int mismatches = 0;
    int missing    = 0;
    int unexpected = 0;
    // cycles seen since reset dropped
    int startup    = 0;
    // fetch address seen at the previous edge
    word_t last_pc;

    ////////////////////////////////////////////////////////////////////////////
    // queue access for the model
    ////////////////////////////////////////////////////////////////////////////

    task automatic expect_write(input reg_idx_t rd, input word_t value);
        exp_rd.push_back(rd);
        exp_value.push_back(value);
    endtask

    task automatic expect_store(input word_t addr, input word_t data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    function automatic int pending();
        return exp_rd.size() + exp_addr.size();
    endfunction

    function automatic int total_errors();
        return mismatches + missing + unexpected;
    endfunction

    task automatic compare_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            mismatches++;
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // per-event checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_retire();
        reg_idx_t rd;
        word_t    value;
        if (exp_rd.size() == 0) begin
            unexpected++;
            $display("unexpected retire of r%0d = %h at %0t ns, the model has none left",
                     wb_trace.rd, wb_trace.value, $time);
        end else begin
            rd    = exp_rd.pop_front();
            value = exp_value.pop_front();
            compare_word("wb_trace.rd", {27'd0, rd}, {27'd0, wb_trace.rd});
            compare_word("wb_trace.value", value, wb_trace.value);
        end
    endtask

    task automatic check_store();
        word_t addr;
        word_t data;
        if (exp_addr.size() == 0) begin
            unexpected++;
            $display("unexpected store to %h at %0t ns, the model has none left",
                     dmem_req.addr, $time);
        end else begin
            addr = exp_addr.pop_front();
            data = exp_data.pop_front();
            compare_word("dmem_req.addr", addr, dmem_req.addr);
            compare_word("dmem_req.wdata", data, dmem_req.wdata);
        end
    endtask

    // anything still queued never showed up
    task automatic report_leftovers();
        int n_wr;
        int n_st;
        n_wr = exp_rd.size();
        n_st = exp_addr.size();
        if (n_wr != 0) begin
            missing += n_wr;
            $display("%0d expected register writes never retired, first one r%0d",
                     n_wr, exp_rd[0]);
        end
        if (n_st != 0) begin
            missing += n_st;
            $display("%0d expected stores never reached the data port, first one to %h",
                     n_st, exp_addr[0]);
        end
    endtask

    // sampled on the rising edge before the stage registers move
    always @(posedge clk) begin
        if (reset) begin
            startup = 0;
        end else begin
            // pc starts at the reset address and after that holds or steps one word
            if (startup == 0) begin
                compare_word("imem_addr", reset_pc, imem_addr);
            end else if ((imem_addr !== last_pc) && (imem_addr !== last_pc + 32'd4)) begin
                mismatches++;
                $display("** Error at %0t ns: imem_addr expected %h or %h, got %h",
                         $time, last_pc, last_pc + 32'd4, imem_addr);
            end
            last_pc = imem_addr;
            // nothing can reach mem or wb in the first three cycles
            if (startup < 3) begin
                compare_word("wb_trace.valid", 32'd0, {31'd0, wb_trace.valid});
                compare_word("dmem_req.we", 32'd0, {31'd0, dmem_req.we});
                compare_word("dmem_req.re", 32'd0, {31'd0, dmem_req.re});
                startup++;
            end
            if (wb_trace.valid === 1'b1) begin
                check_retire();
            end
            if (dmem_req.we === 1'b1) begin
                check_store();
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/tb_dlx_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dlx_pipeline
    import dlx_pkg::*;
;

    localparam int    prog_len    = 200;
    localparam int    clk_period  = 4;
    localparam word_t start_pc    = 32'd0;
    // two cycles per instruction covers stalls and drain with room to spare
    localparam int    watchdog_ns = (prog_len + 20) * 2 * clk_period;

    logic      clk;
    logic      reset;
    word_t     imem_addr;
    word_t     imem_data;
    dmem_req_t dmem_req;
    word_t     dmem_rdata;
    wb_trace_t wb_trace;

    integer    seed;
    word_t     imem [0:511];
    word_t     dmem [0:63];
    // reference model state
    word_t     model_regs [0:31];
    word_t     model_mem [0:63];

    dlx_pipeline #(.reset_pc(start_pc)) u_dut (
        .clk(clk), .reset(reset), .imem_addr(imem_addr), .imem_data(imem_data),
        .dmem_req(dmem_req), .dmem_rdata(dmem_rdata), .wb_trace(wb_trace)
    );

    dlx_checker #(.reset_pc(start_pc)) u_check (
        .clk(clk), .reset(reset), .imem_addr(imem_addr), .wb_trace(wb_trace),
        .dmem_req(dmem_req)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // memories
    ////////////////////////////////////////////////////////////////////////////

    // both reads are combinational and index words by byte address
    assign imem_data  = imem[imem_addr[10:2]];
    // data comes back only while the read enable is high
    assign dmem_rdata = (dmem_req.re === 1'b1) ? dmem[dmem_req.addr[7:2]] : 'x;

    always @(posedge clk) begin
        if (dmem_req.we === 1'b1) begin
            dmem[dmem_req.addr[7:2]] <= dmem_req.wdata;
        end
    end

    // every bit of the index shows up in the word
    function automatic word_t fill_word(input int idx);
        return 32'hc0de_0000 ^ (idx * 32'h0101_0101) ^ (idx << 20);
    endfunction

    function automatic logic [5:0] pick_funct(input logic [2:0] sel);
        case (sel % 5)
            0:       return fn_add;
            1:       return fn_sub;
            2:       return fn_and;
            3:       return fn_or;
            default: return fn_slt;
        endcase
    endfunction

    // registers limited to r0..r7 so dependencies are frequent
    task automatic build_program();
        word_t    r;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        logic [15:0] off;
        for (int i = 0; i < 512; i++) begin
            imem[i] = nop_instr;
        end
        for (int i = 0; i < prog_len; i++) begin
            r   = $random(seed);
            rs1 = {2'b00, r[2:0]};
            rs2 = {2'b00, r[5:3]};
            rd  = {2'b00, r[8:6]};
            // word offset below 256 off an r0 base
            off = {8'd0, r[17:12], 2'b00};
            case (r[31:30])
                2'd0:    imem[i] = {op_rtype, rs1, rs2, rd, 5'd0, pick_funct(r[11:9])};
                2'd1:    imem[i] = {op_addi, rs1, rd, r[27:12]};
                2'd2:    imem[i] = {op_lw, 5'd0, rd, off};
                default: imem[i] = {op_sw, 5'd0, rs2, off};
            endcase
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i] = fill_word(i);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // in-order reference model
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_model();
        word_t    instr;
        word_t    a;
        word_t    b;
        word_t    imm;
        word_t    res;
        reg_idx_t rd;
        logic     writes;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            model_mem[i] = fill_word(i);
        end
        for (int i = 0; i < prog_len; i++) begin
            instr  = imem[i];
            a      = model_regs[instr[25:21]];
            b      = model_regs[instr[20:16]];
            imm    = {{16{instr[15]}}, instr[15:0]};
            rd     = instr[20:16];
            writes = 1'b1;
            res    = '0;
            case (instr[31:26])
                op_rtype: begin
                    rd = instr[15:11];
                    case (instr[5:0])
                        fn_add:  res = a + b;
                        fn_sub:  res = a - b;
                        fn_and:  res = a & b;
                        fn_or:   res = a | b;
                        fn_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: writes = 1'b0;
                    endcase
                end
                op_addi: res = a + imm;
                op_lw:   res = model_mem[(a + imm) >> 2 & 32'h3f];
                op_sw: begin
                    writes = 1'b0;
                    model_mem[(a + imm) >> 2 & 32'h3f] = b;
                    u_check.expect_store(a + imm, b);
                end
                default: writes = 1'b0;
            endcase
            // r0 stays zero and never retires on the trace
            if (writes && (rd != 5'd0)) begin
                model_regs[rd] = res;
                u_check.expect_write(rd, res);
            end
        end
    endtask

    task automatic print_error_counts();
        $display("errors: %0d mismatches, %0d missing, %0d unexpected",
                 u_check.mismatches, u_check.missing, u_check.unexpected);
    endtask

    initial begin
        seed  = 32'h7b7e;
        reset = 1'b1;
        build_program();
        run_model();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // program done once the checker has consumed every expected event
        while (u_check.pending() != 0) begin
            @(negedge clk);
        end
        // a few more cycles to catch stray retires or stores
        repeat (10) @(negedge clk);
        u_check.report_leftovers();
        print_error_counts();
        if (u_check.total_errors() == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(watchdog_ns);
        $display("timeout after %0d ns, the program did not finish retiring", watchdog_ns);
        u_check.report_leftovers();
        print_error_counts();
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
